/* euro_pkg.sv */
// Shared types and constants for the four-channel codec path
// Sample and frame types, fixed calibration tables
// Codec and UART timing, telemetry framer states, saturation helper
package euro_pkg;

    typedef logic signed [15:0] sample_t;

    // Channel 0 sits in the top bits so it leaves the serializer first
    typedef struct packed {
        sample_t ch0;
        sample_t ch1;
        sample_t ch2;
        sample_t ch3;
    } quad_t;

    // Gain is Q2.14
    typedef struct packed {
        sample_t            offset;
        logic signed [15:0] gain;
    } cal_entry_t;

    typedef cal_entry_t [3:0] cal_table_t;

    localparam int CAL_SHIFT = 14;

    // Codec serial timing
    localparam int BICK_DIV     = 4;
    localparam int SLOT_BITS    = 16;
    localparam int SLOTS        = 4;
    localparam int FRAME_CYCLES = BICK_DIV * SLOT_BITS * SLOTS;
    localparam int BICK_W       = $clog2(BICK_DIV);
    localparam int FRAME_CNT_W  = $clog2(FRAME_CYCLES);
    localparam int PDN_DELAY    = 8;

    // UART bit time, short for simulation
    localparam int CLKS_PER_BIT = 16;

    // Entry index is the channel number
    localparam cal_table_t IN_CAL = {
        cal_entry_t'{-16'sd96, 16'sd16420},
        cal_entry_t'{16'sd208, 16'sd17104},
        cal_entry_t'{-16'sd145, 16'sd16611},
        cal_entry_t'{16'sd312, 16'sd16892}
    };

    localparam cal_table_t OUT_CAL = {
        cal_entry_t'{-16'sd60, 16'sd20315},
        cal_entry_t'{16'sd75, 16'sd19870},
        cal_entry_t'{-16'sd210, 16'sd20980},
        cal_entry_t'{16'sd150, 16'sd21450}
    };

    typedef enum logic [2:0] {
        SEND_C,
        SEND_H,
        SEND_ID,
        SEND_MSB,
        SEND_LSB
    } framer_state_t;

    // Clamp a wide signed result to the 16-bit sample range
    function automatic sample_t sat16(input logic signed [19:0] v);
        if (v > 20'sd32767) begin
            return 16'sh7fff;
        end else if (v < -20'sd32768) begin
            return 16'sh8000;
        end
        return v[15:0];
    endfunction

endpackage

/* codec_serial.sv */
// Serial codec port
// Power-down release, bit and frame clock generation
// ADC slot deserializer with frame strobe, DAC slot serializer
`timescale 1ns/100ps

module codec_serial (
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             adc_data,
    input  euro_pkg::quad_t  dac_frame,
    input  logic             dac_valid,
    output logic             dac_data,
    output logic             bick,
    output logic             lrck,
    output logic             pdn,
    output euro_pkg::quad_t  adc_frame,
    output logic             frame_strobe
);

    logic [$clog2(euro_pkg::PDN_DELAY)-1:0] pdn_cnt;
    logic [euro_pkg::FRAME_CNT_W-1:0]       cnt;
    logic [euro_pkg::FRAME_CNT_W-1:0]       cnt_nx;
    logic [$bits(euro_pkg::quad_t)-1:0]     adc_sr;
    logic [$bits(euro_pkg::quad_t)-1:0]     dac_sr;
    logic [$bits(euro_pkg::quad_t)-1:0]     dac_pend;
    logic                                   sample_now;
    logic                                   last_bit;

    assign cnt_nx = cnt + 1'b1;

    // Rising bick has been seen for one cycle, data is stable
    assign sample_now = pdn && (int'(cnt[euro_pkg::BICK_W-1:0]) == euro_pkg::BICK_DIV / 2);
    assign last_bit   = sample_now &&
                        (int'(cnt) == euro_pkg::FRAME_CYCLES - euro_pkg::BICK_DIV / 2);

    // Hold the converter in power-down for a few cycles after reset
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pdn_cnt <= '0;
            pdn     <= 1'b0;
        end else if (!pdn) begin
            if (int'(pdn_cnt) == euro_pkg::PDN_DELAY - 1) begin
                pdn <= 1'b1;
            end
            pdn_cnt <= pdn_cnt + 1'b1;
        end
    end

    // Counter starts on the last bit so the first frame opens on a falling bick
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= euro_pkg::FRAME_CNT_W'(euro_pkg::FRAME_CYCLES - euro_pkg::BICK_DIV);
            bick         <= 1'b0;
            lrck         <= 1'b0;
            dac_data     <= 1'b0;
            dac_sr       <= '0;
            dac_pend     <= '0;
            frame_strobe <= 1'b0;
        end else begin
            frame_strobe <= last_bit;
            if (dac_valid) begin
                dac_pend <= dac_frame;
            end
            if (pdn) begin
                cnt  <= cnt_nx;
                bick <= cnt_nx[euro_pkg::BICK_W-1];
                // High for slots 0 and 1
                lrck <= ~cnt_nx[euro_pkg::FRAME_CNT_W-1];
                if (cnt_nx == '0) begin
                    dac_data <= dac_pend[$bits(dac_pend)-1];
                    dac_sr   <= {dac_pend[$bits(dac_pend)-2:0], 1'b0};
                end else if (cnt_nx[euro_pkg::BICK_W-1:0] == '0) begin
                    dac_data <= dac_sr[$bits(dac_sr)-1];
                    dac_sr   <= {dac_sr[$bits(dac_sr)-2:0], 1'b0};
                end
            end
        end
    end

    // ADC shifter, MSB first, ch0 first
    always_ff @(posedge CLK) begin
        if (sample_now) begin
            adc_sr <= {adc_sr[$bits(adc_sr)-2:0], adc_data};
        end
        if (last_bit) begin
            adc_frame <= {adc_sr[$bits(adc_sr)-2:0], adc_data};
        end
    end

endmodule

/* sample_cal.sv */
// Per-channel offset and gain calibration
// One shared subtract, multiply, shift and saturate datapath
// walked over the four channels, one channel per cycle
`timescale 1ns/100ps

module sample_cal #(
    parameter euro_pkg::cal_table_t CAL = euro_pkg::IN_CAL
) (
    input  logic            CLK,
    input  logic            rst_n,
    input  euro_pkg::quad_t in_frame,
    input  logic            in_valid,
    output euro_pkg::quad_t out_frame,
    output logic            out_valid
);

    euro_pkg::quad_t      in_q;
    logic [1:0]           idx;
    logic                 busy;
    euro_pkg::sample_t    x;
    euro_pkg::cal_entry_t ent;
    logic signed [16:0]   diff;
    logic signed [32:0]   prod;
    euro_pkg::sample_t    y;

    always_comb begin
        case (idx)
            2'd0:    x = in_q.ch0;
            2'd1:    x = in_q.ch1;
            2'd2:    x = in_q.ch2;
            default: x = in_q.ch3;
        endcase
    end

    assign ent  = CAL[idx];
    assign diff = 17'(x) - 17'(ent.offset);
    assign prod = 33'(diff) * 33'(ent.gain);
    assign y    = euro_pkg::sat16(20'(prod >>> euro_pkg::CAL_SHIFT));

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            idx       <= 2'd0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (in_valid) begin
                busy <= 1'b1;
                idx  <= 2'd0;
            end else if (busy) begin
                idx <= idx + 2'd1;
                // Last channel stored on this edge
                if (idx == 2'd3) begin
                    busy      <= 1'b0;
                    out_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            in_q <= in_frame;
        end
        if (busy) begin
            case (idx)
                2'd0:    out_frame.ch0 <= y;
                2'd1:    out_frame.ch1 <= y;
                2'd2:    out_frame.ch2 <= y;
                default: out_frame.ch3 <= y;
            endcase
        end
    end

endmodule

/* vca_core.sv */
// Voltage-controlled amplifier core
// ch0 and ch1 are audio scaled by the positive part of ch1 and ch3
// ch2 and ch3 carry the dry audio of ch0 and ch2
`timescale 1ns/100ps

module vca_core (
    input  logic            CLK,
    input  logic            rst_n,
    input  euro_pkg::quad_t in_frame,
    input  logic            in_valid,
    output euro_pkg::quad_t out_frame,
    output logic            out_valid
);

    euro_pkg::sample_t  cv0;
    euro_pkg::sample_t  cv1;
    logic signed [31:0] p0;
    logic signed [31:0] p1;
    euro_pkg::sample_t  dry0;
    euro_pkg::sample_t  dry1;
    logic               v1;

    // Negative control voltage closes the amplifier
    assign cv0 = in_frame.ch1[15] ? '0 : in_frame.ch1;
    assign cv1 = in_frame.ch3[15] ? '0 : in_frame.ch3;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            v1        <= in_valid;
            out_valid <= v1;
        end
    end

    // Stage 1 multiply, stage 2 scale and assemble
    always_ff @(posedge CLK) begin
        if (in_valid) begin
            p0   <= 32'(in_frame.ch0) * 32'(cv0);
            p1   <= 32'(in_frame.ch2) * 32'(cv1);
            dry0 <= in_frame.ch0;
            dry1 <= in_frame.ch2;
        end
        if (v1) begin
            out_frame.ch0 <= euro_pkg::sat16(20'(p0 >>> euro_pkg::CAL_SHIFT));
            out_frame.ch1 <= euro_pkg::sat16(20'(p1 >>> euro_pkg::CAL_SHIFT));
            out_frame.ch2 <= dry0;
            out_frame.ch3 <= dry1;
        end
    end

endmodule

/* uart_tx.sv */
// 8N1 UART transmitter, LSB first
// Start is taken while idle, busy covers start, data and stop bits
`timescale 1ns/100ps

module uart_tx (
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       tx_busy
);

    logic [9:0]                                  sr;
    logic [$clog2(euro_pkg::CLKS_PER_BIT)-1:0]   clk_cnt;
    logic [3:0]                                  bit_cnt;

    // Line follows the low bit of the shifter, all ones when idle
    assign tx = sr[0];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            sr      <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                sr      <= {1'b1, tx_data, 1'b0};
                clk_cnt <= '0;
                bit_cnt <= '0;
                tx_busy <= 1'b1;
            end
        end else if (int'(clk_cnt) == euro_pkg::CLKS_PER_BIT - 1) begin
            clk_cnt <= '0;
            sr      <= {1'b1, sr[9:1]};
            // Stop bit has run its full time
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

/* telemetry_framer.sv */
// Telemetry packet builder for the UART
// Packet is "C", "H", channel digit, sample MSB, sample LSB
// Channel advances after every packet
`timescale 1ns/100ps

module telemetry_framer (
    input  logic            CLK,
    input  logic            rst_n,
    input  euro_pkg::quad_t cal_frame,
    input  logic            tx_busy,
    output logic            tx_start,
    output logic [7:0]      tx_data
);

    euro_pkg::framer_state_t state;
    logic [1:0]              ch;
    euro_pkg::sample_t       sel;
    euro_pkg::sample_t       snap;
    logic                    issue;

    // Busy rises one cycle late, so skip the cycle right after a start
    assign issue = !tx_busy && !tx_start;

    always_comb begin
        case (ch)
            2'd0:    sel = cal_frame.ch0;
            2'd1:    sel = cal_frame.ch1;
            2'd2:    sel = cal_frame.ch2;
            default: sel = cal_frame.ch3;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= euro_pkg::SEND_C;
            ch       <= 2'd0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= issue;
            if (issue) begin
                case (state)
                    euro_pkg::SEND_C:   state <= euro_pkg::SEND_H;
                    euro_pkg::SEND_H:   state <= euro_pkg::SEND_ID;
                    euro_pkg::SEND_ID:  state <= euro_pkg::SEND_MSB;
                    euro_pkg::SEND_MSB: state <= euro_pkg::SEND_LSB;
                    default: begin
                        state <= euro_pkg::SEND_C;
                        ch    <= ch + 2'd1;
                    end
                endcase
            end
        end
    end

    // Byte for the start issued this cycle
    always_ff @(posedge CLK) begin
        if (issue) begin
            case (state)
                euro_pkg::SEND_C: begin
                    tx_data <= "C";
                    snap    <= sel;
                end
                euro_pkg::SEND_H:   tx_data <= "H";
                euro_pkg::SEND_ID:  tx_data <= 8'h30 + {6'd0, ch};
                euro_pkg::SEND_MSB: tx_data <= snap[15:8];
                default:            tx_data <= snap[7:0];
            endcase
        end
    end

endmodule

/* euro_top.sv */
// Codec board top level
// Codec port, input and output calibration, VCA core, UART telemetry
`timescale 1ns/100ps

module euro_top (
    input  logic CLK,
    input  logic rst_n,
    input  logic adc_data,
    output logic dac_data,
    output logic bick,
    output logic lrck,
    output logic pdn,
    output logic tx
);

    euro_pkg::quad_t adc_frame;
    euro_pkg::quad_t adc_inv;
    euro_pkg::quad_t cal_in;
    euro_pkg::quad_t core_out;
    euro_pkg::quad_t dac_frame;
    logic            frame_strobe;
    logic            cal_in_valid;
    logic            core_valid;
    logic            dac_valid;
    logic            tx_start;
    logic [7:0]      tx_data;
    logic            tx_busy;

    // Analog front end inverts every input
    assign adc_inv = ~adc_frame;

    codec_serial u_codec (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .adc_data     (adc_data),
        .dac_frame    (dac_frame),
        .dac_valid    (dac_valid),
        .dac_data     (dac_data),
        .bick         (bick),
        .lrck         (lrck),
        .pdn          (pdn),
        .adc_frame    (adc_frame),
        .frame_strobe (frame_strobe)
    );

    sample_cal #(.CAL(euro_pkg::IN_CAL)) u_in_cal (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_frame  (adc_inv),
        .in_valid  (frame_strobe),
        .out_frame (cal_in),
        .out_valid (cal_in_valid)
    );

    vca_core u_vca (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_frame  (cal_in),
        .in_valid  (cal_in_valid),
        .out_frame (core_out),
        .out_valid (core_valid)
    );

    sample_cal #(.CAL(euro_pkg::OUT_CAL)) u_out_cal (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_frame  (core_out),
        .in_valid  (core_valid),
        .out_frame (dac_frame),
        .out_valid (dac_valid)
    );

    telemetry_framer u_framer (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .cal_frame (cal_in),
        .tx_busy   (tx_busy),
        .tx_start  (tx_start),
        .tx_data   (tx_data)
    );

    uart_tx u_uart (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

/* euro_props.sv */
// Concurrent assertions on the codec board top level
// Reset values, serial port clocking, frame strobe width
`timescale 1ns/100ps

module euro_props (
    input logic CLK,
    input logic rst_n,
    input logic tx,
    input logic pdn,
    input logic bick,
    input logic lrck,
    input logic frame_strobe
);

    // Sampled mid-cycle so the first reset edge has already taken effect
    reset_idle: assert property (@(negedge CLK) !rst_n |-> (tx && !pdn))
        else $error("tx or pdn wrong during reset");

    // Word clock moves only together with a falling bit clock
    lrck_on_fall: assert property (@(posedge CLK) disable iff (!rst_n)
        (lrck != $past(lrck)) |-> $fell(bick))
        else $error("lrck changed away from a falling bick");

    strobe_single: assert property (@(posedge CLK) disable iff (!rst_n)
        frame_strobe |=> !frame_strobe)
        else $error("frame_strobe longer than one cycle");

endmodule

bind euro_top euro_props u_props (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .tx           (tx),
    .pdn          (pdn),
    .bick         (bick),
    .lrck         (lrck),
    .frame_strobe (frame_strobe)
);

/* tb_euro_top.sv */
// Testbench for the codec board top level
// Codec model on the serial port, UART receiver for telemetry
// Stimulus table, reference model of inversion, calibration and VCA
`timescale 1ns/100ps

module tb_euro_top;

    localparam int NUM_ENTRIES      = 8;
    localparam int FRAMES_PER_ENTRY = 12;
    // Two extra frames flush the DAC path
    localparam int TOTAL_FRAMES     = NUM_ENTRIES * FRAMES_PER_ENTRY + 2;
    localparam int CYCLE_LIMIT      = (NUM_ENTRIES * FRAMES_PER_ENTRY + 4)
                                      * euro_pkg::FRAME_CYCLES + 64;
    localparam int VCA_SHIFT        = 14;
    localparam int MIN_PACKETS      = 8;

    // Raw ADC words and expected saturation codes per channel
    // Code 0 none, 1 positive full scale, 2 negative full scale, 3 output cal of zero
    typedef struct packed {
        euro_pkg::quad_t raw;
        logic [7:0]      codes;
    } stim_t;

    logic CLK;
    logic rst_n;
    logic adc_data;
    logic dac_data;
    logic bick;
    logic lrck;
    logic pdn;
    logic tx;

    stim_t           stim [NUM_ENTRIES];
    euro_pkg::quad_t exp_cal [NUM_ENTRIES];
    euro_pkg::quad_t exp_dac [NUM_ENTRIES];
    euro_pkg::quad_t adc_word;
    logic [63:0]     dac_word;
    logic [31:0]     seed;
    logic            bick_q;
    logic            lrck_q;
    logic            started;
    int              frame_idx;
    int              bpos;
    int              dac_done;
    int              cycles;
    int              dac_errs;
    int              uart_errs;
    int              misc_errs;
    int              pkt_pos;
    int              pkt_frame;
    int              pkts_checked;
    logic [1:0]      pkt_ch;
    logic [7:0]      pkt_msb;

    euro_top u_dut (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .adc_data (adc_data),
        .dac_data (dac_data),
        .bick     (bick),
        .lrck     (lrck),
        .pdn      (pdn),
        .tx       (tx)
    );

    always #50 CLK = ~CLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic euro_pkg::sample_t clamp_sample(input longint v);
        if (v > 32767) begin
            return 16'sh7fff;
        end else if (v < -32768) begin
            return 16'sh8000;
        end
        return euro_pkg::sample_t'(v);
    endfunction

    function automatic euro_pkg::sample_t pick(input euro_pkg::quad_t q, input int c);
        case (c)
            0:       return q.ch0;
            1:       return q.ch1;
            2:       return q.ch2;
            default: return q.ch3;
        endcase
    endfunction

    // Per channel y = sat(((x - offset) * gain) >>> 14)
    function automatic euro_pkg::quad_t apply_cal(input euro_pkg::quad_t x,
                                                  input euro_pkg::cal_table_t t);
        euro_pkg::sample_t ys [4];
        longint            d;
        for (int c = 0; c < 4; c++) begin
            d     = longint'(pick(x, c)) - longint'(t[c].offset);
            ys[c] = clamp_sample((d * longint'(t[c].gain)) >>> euro_pkg::CAL_SHIFT);
        end
        return {ys[0], ys[1], ys[2], ys[3]};
    endfunction

    function automatic euro_pkg::quad_t vca_model(input euro_pkg::quad_t x);
        longint cv0;
        longint cv1;
        cv0 = (x.ch1 < 0) ? 0 : longint'(x.ch1);
        cv1 = (x.ch3 < 0) ? 0 : longint'(x.ch3);
        return {clamp_sample((longint'(x.ch0) * cv0) >>> VCA_SHIFT),
                clamp_sample((longint'(x.ch2) * cv1) >>> VCA_SHIFT),
                x.ch0, x.ch2};
    endfunction

    function automatic int entry_of(input int f);
        int e;
        e = f / FRAMES_PER_ENTRY;
        return (e > NUM_ENTRIES - 1) ? NUM_ENTRIES - 1 : e;
    endfunction

    function automatic euro_pkg::sample_t code_value(input logic [1:0] code, input int c);
        if (code == 2'd1) begin
            return 16'sh7fff;
        end else if (code == 2'd2) begin
            return 16'sh8000;
        end
        return pick(apply_cal('0, euro_pkg::OUT_CAL), c);
    endfunction

    task automatic set_entry(input int i, input logic [15:0] w0, input logic [15:0] w1,
                             input logic [15:0] w2, input logic [15:0] w3,
                             input logic [7:0] codes);
        stim[i].raw   = {w0, w1, w2, w3};
        stim[i].codes = codes;
    endtask

    // DAC frame f carries the words predicted from ADC frame f-2
    task automatic check_dac(input int f, input euro_pkg::quad_t got);
        int                e;
        euro_pkg::sample_t g;
        euro_pkg::sample_t want;
        logic [1:0]        code;
        if (f < 2) begin
            return;
        end
        e = entry_of(f - 2);
        for (int c = 0; c < 4; c++) begin
            g    = pick(got, c);
            want = pick(exp_dac[e], c);
            code = stim[e].codes[2*c +: 2];
            assert (g === want) else begin
                dac_errs++;
                $display("mismatch at %0t: dac frame %0d ch%0d got %0d expected %0d",
                         $time, f, c, g, want);
            end
            if (code != 2'd0) begin
                assert (g === code_value(code, c)) else begin
                    dac_errs++;
                    $display("mismatch at %0t: dac frame %0d ch%0d got %0d limit %0d",
                             $time, f, c, g, code_value(code, c));
                end
            end
        end
    endtask

    task automatic take_byte(input logic [7:0] b);
        euro_pkg::sample_t want;
        case (pkt_pos)
            0: assert (b == 8'h43) else begin
                uart_errs++;
                $display("mismatch at %0t: packet byte 0 got %h expected 43", $time, b);
            end
            1: assert (b == 8'h48) else begin
                uart_errs++;
                $display("mismatch at %0t: packet byte 1 got %h expected 48", $time, b);
            end
            2: assert (b == 8'h30 + {6'd0, pkt_ch}) else begin
                uart_errs++;
                $display("mismatch at %0t: channel digit got %h expected ch%0d",
                         $time, b, pkt_ch);
            end
            3: pkt_msb = b;
            default: begin
                // Payload is stable once two frames of one entry have passed
                if (pkt_frame >= 2 && entry_of(pkt_frame) == entry_of(pkt_frame - 2)) begin
                    want = pick(exp_cal[entry_of(pkt_frame)], int'(pkt_ch));
                    pkts_checked++;
                    assert ({pkt_msb, b} === want) else begin
                        uart_errs++;
                        $display("mismatch at %0t: telemetry ch%0d got %h expected %h",
                                 $time, pkt_ch, {pkt_msb, b}, want);
                    end
                end
                pkt_ch = pkt_ch + 2'd1;
            end
        endcase
        pkt_pos = (pkt_pos == 4) ? 0 : pkt_pos + 1;
    endtask

    // Codec model sees the values from before the current edge
    always @(posedge CLK) begin
        assert (!(bick === 1'b1 && pdn !== 1'b1)) else begin
            misc_errs++;
            $display("bit clock ran while the converter was powered down at %0t", $time);
        end
        if (bick_q === 1'b1 && bick === 1'b0) begin
            if (lrck === 1'b1 && lrck_q === 1'b0) begin
                if (started) begin
                    frame_idx++;
                end
                started = 1'b1;
                bpos    = 0;
            end else begin
                bpos++;
            end
            if (started) begin
                adc_word = stim[entry_of(frame_idx)].raw;
                adc_data <= adc_word[63 - bpos];
                // Word clock is high for the first two slots only
                assert (lrck === (bpos < 32)) else begin
                    misc_errs++;
                    $display("mismatch at %0t: lrck %b at frame bit %0d",
                             $time, lrck, bpos);
                end
            end
        end
        if (started && bick_q === 1'b0 && bick === 1'b1) begin
            dac_word[63 - bpos] = dac_data;
            if (bpos == 63) begin
                check_dac(frame_idx, dac_word);
                dac_done = frame_idx + 1;
            end
        end
        bick_q = bick;
        lrck_q = lrck;
    end

    // UART receiver sampling mid-bit
    initial begin : uart_rx
        logic [7:0] b;
        @(posedge rst_n);
        forever begin
            @(posedge CLK);
            if (tx === 1'b0) begin
                if (pkt_pos == 0) begin
                    pkt_frame = started ? frame_idx : -1;
                end
                repeat (euro_pkg::CLKS_PER_BIT / 2) @(posedge CLK);
                for (int i = 0; i < 8; i++) begin
                    repeat (euro_pkg::CLKS_PER_BIT) @(posedge CLK);
                    b[i] = tx;
                end
                repeat (euro_pkg::CLKS_PER_BIT) @(posedge CLK);
                assert (tx === 1'b1) else begin
                    uart_errs++;
                    $display("UART stop bit missing at %0t", $time);
                end
                take_byte(b);
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        CLK          = 1'b0;
        rst_n        = 1'b0;
        adc_data     = 1'b0;
        bick_q       = 1'b0;
        lrck_q       = 1'b0;
        started      = 1'b0;
        frame_idx    = 0;
        bpos         = 0;
        dac_done     = 0;
        cycles       = 0;
        dac_errs     = 0;
        uart_errs    = 0;
        misc_errs    = 0;
        pkt_pos      = 0;
        pkt_frame    = -1;
        pkts_checked = 0;
        pkt_ch       = 2'd0;
        pkt_msb      = 8'h00;
        seed         = 32'hfe09_df0b;

        set_entry(0, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 8'b00_00_00_00);
        // Full scale audio with negative CV on ch3
        set_entry(1, 16'h8000, 16'hbfff, 16'h7fff, 16'h1000, 8'b10_01_11_01);
        set_entry(2, 16'hc000, 16'ha000, 16'h4000, 16'hf000, 8'b00_00_00_00);
        set_entry(3, 16'h7fff, 16'h8000, 16'h8000, 16'h8000, 8'b01_10_01_10);
        set_entry(4, 16'h1234, 16'h5678, 16'h9abc, 16'hdef0, 8'b00_00_00_00);
        // Negative CV on ch1 closes ch0
        set_entry(5, 16'h9000, 16'h4000, 16'h3000, 16'hc000, 8'b00_00_00_11);
        set_entry(6, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 8'b00_00_00_00);
        for (int c = 0; c < 4; c++) begin
            seed = lcg_next(seed);
            stim[6].raw[16*(3-c) +: 16] = seed[31:16];
        end
        set_entry(7, 16'hfff0, 16'hffe0, 16'h0010, 16'h0020, 8'b00_00_00_00);

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            exp_cal[e] = apply_cal(~stim[e].raw, euro_pkg::IN_CAL);
            exp_dac[e] = apply_cal(vca_model(exp_cal[e]), euro_pkg::OUT_CAL);
        end

        repeat (8) @(posedge CLK);
        rst_n <= 1'b1;
        @(posedge CLK);
        assert (tx === 1'b1) else begin
            misc_errs++;
            $display("UART line not idle high after reset");
        end

        wait (dac_done >= TOTAL_FRAMES);
        assert (pkts_checked >= MIN_PACKETS) else begin
            misc_errs++;
            $display("too few telemetry packets checked: %0d", pkts_checked);
        end
        $display("errors: dac %0d, uart %0d, other %0d, packets checked %0d",
                 dac_errs, uart_errs, misc_errs, pkts_checked);
        if (dac_errs + uart_errs + misc_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
euro_pkg.sv
codec_serial.sv
sample_cal.sv
vca_core.sv
uart_tx.sv
telemetry_framer.sv
euro_top.sv
euro_props.sv
tb_euro_top.sv

/* Makefile */
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_euro_top
FLIST  = build.f
OBJDIR = obj_dir
LOG    = sim.log
PASS   = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
